// ==== include/csma_consts.svh ====
// width, ACK timing, LFSR seed and contention window constants for the CSMA/CA controller
`ifndef CSMA_CONSTS_SVH
`define CSMA_CONSTS_SVH

// NAV counter width, low 15 bits of the Duration field
`define CSMA_NAV_W 15

// interframe wait timer width in us ticks
`define CSMA_TIME_W 13

// PHY signal length field width in octets
`define CSMA_LEN_W 16

`define CSMA_LONGEST_ACK_US 44      // worst case ACK airtime

// backoff LFSR state after reset
`define CSMA_LFSR_INIT 32'h1020f0cb

`define CSMA_CW_EXP_MAX 10          // contention window tops out at 1024 slots

`endif

// ==== verilog/csma_mac_pkg.sv ====
// received-frame field bundle, NAV set request and NAV tracker state types
`default_nettype none

`include "csma_consts.svh"

package csma_mac_pkg;

    // fields delivered by the receiver, each with its own strobe or valid
    typedef struct packed {
        logic                   header_valid;   // PHY header decoded ok
        logic                   header_strobe;  // one cycle, start of a frame
        logic [`CSMA_LEN_W-1:0] signal_len;     // PSDU length in octets
        logic                   fcs_strobe;     // one cycle, end of frame
        logic                   fcs_valid;      // FCS check result
        logic                   addr1_valid;
        logic [47:0]            addr1;          // receiver address
        logic                   dur_valid;
        logic [15:0]            duration;       // Duration/ID field
    } rx_frame_t;

    // request to raise the NAV
    typedef struct packed {
        logic                   valid;          // single cycle strobe
        logic [`CSMA_NAV_W-1:0] value;          // in us
    } nav_req_t;

    typedef enum logic [1:0] {
        nav_idle,
        nav_wait_duration,
        nav_check_ra,
        nav_update
    } nav_state_t;

endpackage

`default_nettype wire

// ==== verilog/csma_backoff_pkg.sv ====
// timing configuration, backoff FSM state enum and interframe wait types
`default_nettype none

`include "csma_consts.svh"

package csma_backoff_pkg;

    // software controlled timing, all times in us
    typedef struct packed {
        logic [4:0] slot_time;
        logic [6:0] sifs_time;
        logic       difs_enable;    // DIFS of zero when clear
        logic       eifs_enable;    // clear gives a plain sifs plus two slots
        logic       nav_enable;     // virtual carrier sense on/off
    } timing_cfg_t;

    // random backoff states
    typedef enum logic [2:0] {
        bo_idle,            // no access pending
        bo_ch_busy,         // waiting for the medium to go idle
        bo_wait_plain,      // IFS then grant, no backoff
        bo_wait_backoff,    // IFS then random backoff
        bo_run,             // counting down backoff slots
        bo_suspend,         // backoff frozen while busy
        bo_wait_own         // granted, waiting for own tx
    } backoff_state_t;

    // interframe wait, DIFS or EIFS
    typedef struct packed {
        logic [`CSMA_TIME_W-1:0] ticks;     // in us
    } ifs_wait_t;

endpackage

`default_nettype wire

// ==== verilog/rx_nav_tracker.sv ====
// received-frame tracker module that checks duration, RA and FCS and emits NAV set requests
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module rx_nav_tracker
    import csma_mac_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  rx_frame_t   rx,
    input  logic [47:0] self_addr,
    output nav_req_t    nav_req
);

    nav_state_t             state;
    logic                   req_valid;
    logic [`CSMA_NAV_W-1:0] dur_q;

    // duration field, caught as it goes by
    always_ff @(posedge clk) begin
        if (rx.dur_valid) begin
            dur_q <= rx.duration[`CSMA_NAV_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= nav_idle;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            if (rx.header_strobe) begin
                // any new header restarts tracking, so a lost FCS can't hang us
                state <= rx.header_valid ? nav_wait_duration : nav_idle;
            end else begin
                case (state)
                    nav_wait_duration: begin
                        if (rx.dur_valid && !rx.duration[15]) begin
                            state <= nav_check_ra;  // bit 15 set means AID, no NAV
                        end else if (rx.fcs_strobe) begin
                            state <= nav_idle;
                        end
                    end
                    nav_check_ra: begin
                        if (rx.addr1_valid && (rx.addr1 != self_addr)) begin
                            state <= nav_update;
                        end else if (rx.fcs_strobe) begin
                            state <= nav_idle;      // frame for us, NAV untouched
                        end
                    end
                    nav_update: begin
                        if (rx.fcs_strobe) begin
                            req_valid <= rx.fcs_valid;
                            state     <= nav_idle;
                        end
                    end
                    default: state <= nav_idle;
                endcase
            end
        end
    end

    assign nav_req = '{valid: req_valid, value: dur_q};

    // one request per frame at most
    a_req_single: assert property (@(posedge clk) disable iff (!rstn)
        nav_req.valid |=> !nav_req.valid)
        else $error("nav_req.valid held for more than one cycle");

endmodule

`default_nettype wire

// ==== verilog/nav_timer.sv ====
// NAV register module with take-the-larger update, 1 us countdown and medium idle output
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module nav_timer
    import csma_mac_pkg::*, csma_backoff_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   tick_1us,
    input  logic                   ch_idle,
    input  timing_cfg_t            cfg,
    input  nav_req_t               nav_req,
    output logic [`CSMA_NAV_W-1:0] nav_value,
    output logic                   medium_idle
);

    logic [`CSMA_NAV_W-1:0] nav_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav_q <= '0;
        end else if (nav_req.valid) begin
            // a shorter duration never cuts the NAV
            nav_q <= (nav_req.value > nav_q) ? nav_req.value : nav_q;
        end else if (tick_1us && (nav_q != '0)) begin
            nav_q <= nav_q - 1'b1;
        end
    end

    assign nav_value = nav_q;

    // physical and virtual carrier sense combined
    assign medium_idle = ch_idle && ((nav_q == '0) || !cfg.nav_enable);

endmodule

`default_nettype wire

// ==== verilog/ifs_select.sv ====
// interframe space module with last reception outcome flags and DIFS/EIFS selection
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module ifs_select
    import csma_mac_pkg::*, csma_backoff_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  rx_frame_t   rx,
    input  timing_cfg_t cfg,
    output ifs_wait_t   ifs_wait
);

    logic                    last_fail;
    logic                    short_len;
    logic [`CSMA_TIME_W-1:0] sifs_ext;
    logic [`CSMA_TIME_W-1:0] two_slots;
    logic [`CSMA_TIME_W-1:0] difs_time;
    logic [`CSMA_TIME_W-1:0] eifs_time;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_fail <= 1'b0;
            short_len <= 1'b0;
        end else if (rx.fcs_strobe) begin
            last_fail <= !rx.fcs_valid;
            // 14 or 32 octets (ACK/CTS sized) still gives DIFS
            short_len <= (rx.signal_len == `CSMA_LEN_W'(14)) ||
                         (rx.signal_len == `CSMA_LEN_W'(32));
        end
    end

    assign sifs_ext  = `CSMA_TIME_W'(cfg.sifs_time);
    assign two_slots = `CSMA_TIME_W'({cfg.slot_time, 1'b0});
    assign difs_time = cfg.difs_enable ? (sifs_ext + two_slots) : '0;
    assign eifs_time = cfg.eifs_enable ?
                       (sifs_ext + difs_time + `CSMA_TIME_W'(`CSMA_LONGEST_ACK_US)) :
                       (sifs_ext + two_slots);

    assign ifs_wait = '{ticks: (last_fail && !short_len) ? eifs_time : difs_time};

endmodule

`default_nettype wire

// ==== verilog/backoff_rng.sv ====
// backoff random number module with 32-bit LFSR and slot count masked to the contention window
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module backoff_rng (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        draw,
    input  logic [3:0]                  cw_exp,
    output logic [`CSMA_CW_EXP_MAX-1:0] slot_draw
);

    logic [31:0]                 lfsr;
    logic [3:0]                  cw_clamped;
    logic [`CSMA_CW_EXP_MAX-1:0] slot_mask;

    // XNOR feedback from taps 31, 21, 1, 0
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr <= `CSMA_LFSR_INIT;
        end else if (draw) begin
            lfsr <= {lfsr[30:0], ~^{lfsr[31], lfsr[21], lfsr[1:0]}};
        end
    end

    assign cw_clamped = (cw_exp > 4'(`CSMA_CW_EXP_MAX)) ? 4'(`CSMA_CW_EXP_MAX) : cw_exp;

    // low cw_clamped bits set, all ones at the maximum
    assign slot_mask = ~({`CSMA_CW_EXP_MAX{1'b1}} << cw_clamped);
    assign slot_draw = lfsr[`CSMA_CW_EXP_MAX-1:0] & slot_mask;

    a_slot_in_cw: assert property (@(posedge clk) disable iff (!rstn)
        (slot_draw >> cw_clamped) == '0)
        else $error("slot_draw outside contention window");

endmodule

`default_nettype wire

// ==== verilog/backoff_fsm.sv ====
// random backoff FSM module with IFS wait, slot countdown, suspend and access grant
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module backoff_fsm
    import csma_backoff_pkg::*;
(
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        tick_1us,
    input  logic                        medium_idle,
    input  logic                        new_trigger,
    input  logic                        retrans_trigger,
    input  logic                        tx_ongoing,
    input  ifs_wait_t                   ifs_wait,
    input  timing_cfg_t                 cfg,
    input  logic [`CSMA_CW_EXP_MAX-1:0] slot_draw,
    output logic                        draw,
    output logic                        backoff_done,
    output logic [`CSMA_CW_EXP_MAX-1:0] slot_count
);

    // up to 1023 slots of 31 us each
    localparam int BO_W = `CSMA_CW_EXP_MAX + 5;

    backoff_state_t          state;
    logic [`CSMA_TIME_W-1:0] wait_timer;    // IFS remaining
    logic [BO_W-1:0]         bo_timer;      // backoff remaining
    logic [BO_W-1:0]         bo_load;
    logic                    wait_zero;
    logic                    bo_zero;

    assign bo_load      = BO_W'(slot_draw) * BO_W'(cfg.slot_time);
    assign wait_zero    = (wait_timer == '0);
    assign bo_zero      = (bo_timer == '0);
    assign backoff_done = (state == bo_wait_own);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= bo_idle;
            wait_timer <= '0;
            bo_timer   <= '0;
            draw       <= 1'b0;
            slot_count <= '0;
        end else begin
            // new random number two ticks before the IFS ends
            draw <= (state == bo_wait_backoff) && tick_1us &&
                    (wait_timer == `CSMA_TIME_W'(2));
            case (state)
                bo_idle: begin
                    if (medium_idle) begin
                        if (new_trigger) begin
                            state      <= bo_wait_plain;
                            wait_timer <= ifs_wait.ticks;
                        end else if (retrans_trigger) begin
                            state      <= bo_wait_backoff;
                            wait_timer <= ifs_wait.ticks;
                        end
                    end else if (new_trigger || retrans_trigger) begin
                        state <= bo_ch_busy;    // busy at trigger forces a backoff
                    end
                end
                bo_ch_busy: begin
                    if (medium_idle) begin
                        state      <= bo_wait_backoff;
                        wait_timer <= ifs_wait.ticks;
                    end
                end
                bo_wait_plain: begin
                    if (!medium_idle) begin
                        state <= bo_ch_busy;
                    end else if (wait_zero) begin
                        state      <= bo_wait_own;
                        slot_count <= '0;
                    end else if (tick_1us) begin
                        wait_timer <= wait_timer - 1'b1;
                    end
                end
                bo_wait_backoff: begin
                    if (!medium_idle) begin
                        state <= bo_ch_busy;
                    end else if (wait_zero) begin
                        state      <= bo_run;
                        bo_timer   <= bo_load;
                        slot_count <= slot_draw;
                    end else if (tick_1us) begin
                        wait_timer <= wait_timer - 1'b1;
                    end
                end
                bo_run: begin
                    if (!medium_idle) begin
                        // remaining time frozen, nothing left means start over
                        state <= bo_zero ? bo_ch_busy : bo_suspend;
                    end else if (bo_zero) begin
                        state <= bo_wait_own;
                    end else if (tick_1us) begin
                        bo_timer <= bo_timer - 1'b1;
                    end
                end
                bo_suspend: begin
                    if (medium_idle) begin
                        state <= bo_run;
                    end
                end
                bo_wait_own: begin
                    if (tx_ongoing) begin
                        state <= bo_idle;   // grant held until tx starts
                    end
                end
                default: state <= bo_idle;
            endcase
        end
    end

    // grant only follows a cycle of idle medium
    a_grant_on_idle: assert property (@(posedge clk) disable iff (!rstn)
        $rose(backoff_done) |-> $past(medium_idle))
        else $error("backoff_done rose on a busy medium");

endmodule

`default_nettype wire

// ==== verilog/csma_ca.sv ====
// CSMA/CA channel access top module connecting NAV tracking, IFS selection and random backoff
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module csma_ca
    import csma_mac_pkg::*, csma_backoff_pkg::*;
(
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        tick_1us,
    input  logic                        ch_idle,
    input  rx_frame_t                   rx,
    input  logic [47:0]                 self_addr,
    input  timing_cfg_t                 cfg,
    input  logic [3:0]                  cw_exp,
    input  logic                        new_trigger,
    input  logic                        retrans_trigger,
    input  logic                        tx_ongoing,
    output logic                        backoff_done,
    output logic [`CSMA_NAV_W-1:0]      nav_value,
    output logic                        medium_idle,
    output logic [`CSMA_CW_EXP_MAX-1:0] slot_count
);

    nav_req_t                    nav_req;
    ifs_wait_t                   ifs_wait;
    logic                        draw;
    logic [`CSMA_CW_EXP_MAX-1:0] slot_draw;

    rx_nav_tracker rx_nav_tracker_inst (
        .clk       (clk),
        .rstn      (rstn),
        .rx        (rx),
        .self_addr (self_addr),
        .nav_req   (nav_req)
    );

    nav_timer nav_timer_inst (
        .clk         (clk),
        .rstn        (rstn),
        .tick_1us    (tick_1us),
        .ch_idle     (ch_idle),
        .cfg         (cfg),
        .nav_req     (nav_req),
        .nav_value   (nav_value),
        .medium_idle (medium_idle)
    );

    ifs_select ifs_select_inst (
        .clk      (clk),
        .rstn     (rstn),
        .rx       (rx),
        .cfg      (cfg),
        .ifs_wait (ifs_wait)
    );

    backoff_rng backoff_rng_inst (
        .clk       (clk),
        .rstn      (rstn),
        .draw      (draw),
        .cw_exp    (cw_exp),
        .slot_draw (slot_draw)
    );

    backoff_fsm backoff_fsm_inst (
        .clk             (clk),
        .rstn            (rstn),
        .tick_1us        (tick_1us),
        .medium_idle     (medium_idle),
        .new_trigger     (new_trigger),
        .retrans_trigger (retrans_trigger),
        .tx_ongoing      (tx_ongoing),
        .ifs_wait        (ifs_wait),
        .cfg             (cfg),
        .slot_draw       (slot_draw),
        .draw            (draw),
        .backoff_done    (backoff_done),
        .slot_count      (slot_count)
    );

endmodule

`default_nettype wire

// ==== testbench/csma_ca_tb.sv ====
// testbench for the CSMA/CA controller with clock, reset, frame and access stimulus, and checks
`default_nettype none
`timescale 1ns/1ps

`include "csma_consts.svh"

module csma_ca_tb
    import csma_mac_pkg::*, csma_backoff_pkg::*;
();

    localparam int SLOT = 3;
    localparam int SIFS = 4;
    localparam int DIFS = SIFS + 2 * SLOT;
    localparam int EIFS = SIFS + DIFS + `CSMA_LONGEST_ACK_US;
    localparam logic [47:0] SELF_ADDR  = 48'h0011_2233_4455;
    localparam logic [47:0] OTHER_ADDR = 48'h00aa_bbcc_ddee;

    logic                        clk = 1'b0;
    logic                        rstn;
    logic                        tick_1us;
    logic                        ch_idle;
    rx_frame_t                   rx;
    logic [47:0]                 self_addr;
    timing_cfg_t                 cfg;
    logic [3:0]                  cw_exp;
    logic                        new_trigger;
    logic                        retrans_trigger;
    logic                        tx_ongoing;
    logic                        backoff_done;
    logic [`CSMA_NAV_W-1:0]      nav_value;
    logic                        medium_idle;
    logic [`CSMA_CW_EXP_MAX-1:0] slot_count;

    integer seed;
    int     check_errors;
    int     timeouts;
    int     tick_cnt;
    int     idle_ticks;         // idle ticks since the trigger
    logic   count_en;
    int     snap;
    int     dur1;
    int     cw;
    int     remaining;

    csma_ca csma_ca_inst (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    // 1 us tick every 4 clocks keeps the run short
    always @(negedge clk) begin
        if (!rstn) begin
            tick_cnt = 0;
            tick_1us = 1'b0;
        end else begin
            tick_cnt = (tick_cnt + 1) % 4;
            tick_1us = (tick_cnt == 3);
        end
    end

    always @(posedge clk) begin
        if (!count_en) begin
            idle_ticks <= 0;
        end else if (tick_1us && medium_idle) begin
            idle_ticks <= idle_ticks + 1;
        end
    end

    task automatic report_error(input string msg);
        check_errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // nav_enable stays on so any NAV holds the medium busy
    nav_busy: assert property (@(posedge clk) disable iff (!rstn)
        (nav_value != '0) |-> !medium_idle)
        else report_error("medium_idle high while NAV is nonzero");
    idle_follows_cs: assert property (@(posedge clk) disable iff (!rstn)
        (nav_value == '0) |-> (medium_idle == ch_idle))
        else report_error("medium_idle differs from ch_idle with NAV at zero");
    grant_held: assert property (@(posedge clk) disable iff (!rstn)
        (backoff_done && !tx_ongoing) |=> backoff_done)
        else report_error("backoff_done dropped before tx_ongoing");

    task automatic play_frame(input logic [47:0] ra, input logic [15:0] dur,
                              input logic fcs_ok, input logic [15:0] len);
        @(negedge clk);
        rx.header_valid  = 1'b1;
        rx.header_strobe = 1'b1;
        rx.signal_len    = len;
        @(negedge clk);
        rx.header_strobe = 1'b0;
        rx.dur_valid     = 1'b1;
        rx.duration      = dur;
        @(negedge clk);
        rx.dur_valid   = 1'b0;
        rx.addr1_valid = 1'b1;
        rx.addr1       = ra;
        @(negedge clk);
        rx.addr1_valid = 1'b0;
        rx.fcs_strobe  = 1'b1;
        rx.fcs_valid   = fcs_ok;
        @(negedge clk);
        rx.fcs_strobe = 1'b0;   // request goes out at the edge just passed
    endtask

    task automatic wait_ticks(input int count);
        int seen = 0;
        int n = 0;
        while (seen < count && n < 8 * count + 8) begin
            @(posedge clk);
            if (tick_1us) begin
                seen++;
            end
            n++;
        end
        @(negedge clk);
        if (seen < count) begin
            $display("timeout at %0t: only %0d of %0d ticks seen", $time, seen, count);
            timeouts++;
        end
    endtask

    task automatic wait_nav_zero(input int max_cycles);
        int n = 0;
        while (nav_value != '0 && n < max_cycles) begin
            @(negedge clk);
            assert (!backoff_done) else report_error("backoff_done high while NAV set");
            n++;
        end
        if (nav_value != '0) begin
            $display("timeout at %0t: NAV did not count down to zero", $time);
            timeouts++;
        end
    endtask

    task automatic wait_grant(input int max_cycles);
        int n = 0;
        while (!backoff_done && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!backoff_done) begin
            $display("timeout at %0t: no backoff_done after %0d cycles", $time, max_cycles);
            timeouts++;
        end
    endtask

    task automatic wait_idle_ticks(input int target, input int max_cycles);
        int n = 0;
        while (idle_ticks < target && !backoff_done && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (idle_ticks < target && !backoff_done) begin
            $display("timeout at %0t: idle ticks stuck at %0d", $time, idle_ticks);
            timeouts++;
        end
    endtask

    task automatic start_access(input logic retrans);
        @(negedge clk);
        count_en        = 1'b1;
        new_trigger     = !retrans;
        retrans_trigger = retrans;
        @(negedge clk);
        new_trigger     = 1'b0;
        retrans_trigger = 1'b0;
    endtask

    task automatic hold_busy(input int cycles);
        @(negedge clk);
        ch_idle = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            assert (!backoff_done) else report_error("backoff_done high on busy medium");
        end
        ch_idle = 1'b1;
    endtask

    task automatic release_grant();
        int n = 0;
        @(negedge clk);
        tx_ongoing = 1'b1;
        count_en   = 1'b0;
        while (backoff_done && n < 2) begin
            @(negedge clk);
            n++;
        end
        tx_ongoing = 1'b0;
        assert (!backoff_done) else report_error("backoff_done not cleared after tx_ongoing");
    endtask

    // backoff lower bound, slots drawn within the window
    task automatic check_backoff(input int cw_now);
        int lim;
        lim = (cw_now > `CSMA_CW_EXP_MAX) ? `CSMA_CW_EXP_MAX : cw_now;
        assert (int'(slot_count) < (1 << lim))
            else report_error($sformatf("slot_count %0d outside window", slot_count));
        assert (idle_ticks >= DIFS + int'(slot_count) * SLOT)
            else report_error($sformatf("grant after only %0d idle ticks", idle_ticks));
    endtask

    initial begin
        seed            = 32'h2635_62bc;
        check_errors    = 0;
        timeouts        = 0;
        count_en        = 1'b0;
        rstn            = 1'b0;
        tick_1us        = 1'b0;
        ch_idle         = 1'b1;
        rx              = '0;
        self_addr       = SELF_ADDR;
        cfg             = '{slot_time: 5'(SLOT), sifs_time: 7'(SIFS), difs_enable: 1'b1,
                            eifs_enable: 1'b1, nav_enable: 1'b1};
        cw_exp          = 4'd3;
        new_trigger     = 1'b0;
        retrans_trigger = 1'b0;
        tx_ongoing      = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (!backoff_done && slot_count == '0 && nav_value == '0 && medium_idle == ch_idle)
            else report_error("outputs not cleared after reset");

        // NAV set, countdown, no lowering, ignored frames
        dur1 = 200 + ($random(seed) & 255);
        play_frame(OTHER_ADDR, 16'(dur1), 1'b1, 16'd60);
        @(negedge clk);
        assert (int'(nav_value) == dur1)
            else report_error($sformatf("NAV %0d, expected %0d", nav_value, dur1));
        snap = int'(nav_value);
        wait_ticks(1);
        assert (int'(nav_value) == snap - 1) else report_error("NAV did not fall by one per tick");
        snap = int'(nav_value);
        play_frame(OTHER_ADDR, 16'(dur1 / 2), 1'b1, 16'd60);
        @(negedge clk);
        assert (int'(nav_value) > dur1 / 2 && int'(nav_value) <= snap)
            else report_error("smaller duration changed the NAV");
        snap = int'(nav_value);
        play_frame(SELF_ADDR, 16'd3000 + 16'($random(seed) & 1023), 1'b1, 16'd60);
        @(negedge clk);
        assert (int'(nav_value) <= snap) else report_error("frame to self raised the NAV");
        snap = int'(nav_value);
        play_frame(OTHER_ADDR, 16'd3000, 1'b0, 16'd60);
        @(negedge clk);
        assert (int'(nav_value) <= snap) else report_error("bad FCS frame raised the NAV");
        wait_nav_zero(4000);

        // new packet on an idle medium after a good reception
        play_frame(SELF_ADDR, 16'd0, 1'b1, 16'd60);
        start_access(1'b0);
        wait_grant(400);
        assert (idle_ticks >= DIFS && idle_ticks <= DIFS + 1)
            else report_error($sformatf("DIFS grant after %0d ticks", idle_ticks));
        release_grant();

        // EIFS after a failed long frame, DIFS after a failed 14 octet one
        play_frame(SELF_ADDR, 16'd0, 1'b0, 16'd100);
        start_access(1'b0);
        wait_grant(600);
        assert (idle_ticks >= EIFS)
            else report_error($sformatf("EIFS grant after %0d ticks", idle_ticks));
        release_grant();
        play_frame(SELF_ADDR, 16'd0, 1'b0, 16'd14);
        start_access(1'b0);
        wait_grant(400);
        assert (idle_ticks >= DIFS && idle_ticks <= DIFS + 1)
            else report_error($sformatf("short failed frame gave %0d ticks", idle_ticks));
        release_grant();

        // retransmission backoff with random windows
        play_frame(SELF_ADDR, 16'd0, 1'b1, 16'd60);
        repeat (3) begin
            cw = $random(seed) & 15;
            cw_exp = 4'(cw);
            start_access(1'b1);
            wait_grant(20000);
            check_backoff(cw);
            release_grant();
        end

        // busy medium during the IFS wait, then a NAV during the wait
        cw_exp = 4'd3;
        start_access(1'b0);
        wait_ticks(3);
        hold_busy(60);
        wait_grant(2000);
        check_backoff(3);
        release_grant();
        start_access(1'b0);
        wait_ticks(2);
        play_frame(OTHER_ADDR, 16'd20, 1'b1, 16'd60);
        @(negedge clk);
        wait_nav_zero(400);
        wait_grant(2000);
        check_backoff(3);
        release_grant();

        // busy medium in the middle of the slot countdown
        cw_exp = 4'd10;
        start_access(1'b1);
        wait_idle_ticks(DIFS + 2, 400);
        remaining = DIFS + int'(slot_count) * SLOT - idle_ticks;
        if (!backoff_done && remaining > 4) begin
            hold_busy(remaining * 4 + 8);
        end
        wait_grant(20000);
        check_backoff(10);
        release_grant();

        // plain grant right after a backoff leaves no slot count
        start_access(1'b0);
        wait_grant(400);
        assert (slot_count == '0) else report_error("slot_count nonzero without backoff");
        release_grant();

        repeat (4) @(negedge clk);
        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
verilog/csma_mac_pkg.sv
verilog/csma_backoff_pkg.sv
verilog/rx_nav_tracker.sv
verilog/nav_timer.sv
verilog/ifs_select.sv
verilog/backoff_rng.sv
verilog/backoff_fsm.sv
verilog/csma_ca.sv
testbench/csma_ca_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CSMA/CA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module csma_ca_tb -Mdir "$OBJ" -o csma_ca_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/csma_ca_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1
